// File: Bender.yml
package:
  name: opnd_fetch

export_include_dirs:
  - logic

sources:
  - logic/opnd_pkg.sv
  - logic/opnd_field_decode.sv
  - logic/opnd_addr_gen.sv
  - logic/opnd_hint_match.sv
  - logic/opnd_result_select.sv
  - logic/opnd_fetch_top.sv
  - target: simulation
    files:
      - sim/tb_opnd_fetch.sv

// File: logic/opnd_addr_gen.sv
`timescale 1ns/1ps

module opnd_addr_gen (
  input  opnd_pkg::gpr_set_t gprs,
  input  opnd_pkg::mem_ref_t mem,
  output opnd_pkg::word_t    addr
);

  opnd_pkg::word_t base;
  opnd_pkg::word_t index;
  opnd_pkg::word_t scaled_index;

  // Missing base or index contributes zero
  assign base  = mem.use_base  ? opnd_pkg::gpr_read(gprs, mem.base_sel)  : '0;
  assign index = mem.use_index ? opnd_pkg::gpr_read(gprs, mem.index_sel) : '0;

  // Scale 0..3 gives x1, x2, x4, x8
  assign scaled_index = index << mem.scale;

  // Wraps modulo 2^32 like the hardware AGU
  assign addr = base + scaled_index + mem.disp;

endmodule

// File: logic/opnd_fetch_top.sv
`timescale 1ns/1ps

module opnd_fetch_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  opnd_pkg::instr_t     instr,
  input  opnd_pkg::opnd_ctl_t  ctl,
  input  opnd_pkg::gpr_set_t   gprs,
  input  opnd_pkg::mem_hint_t  hint1,
  input  opnd_pkg::mem_hint_t  hint2,
  output logic                 opnd_valid,
  output opnd_pkg::word_t      opnd0_val,
  output opnd_pkg::word_t      opnd1_val,
  output opnd_pkg::word_t      opnd2_val,
  output opnd_pkg::dest_kind_t dest0_kind,
  output opnd_pkg::dest_kind_t dest1_kind,
  output opnd_pkg::regsel_t    dest0_sel,
  output opnd_pkg::regsel_t    dest1_sel,
  output logic                 disp_1byte_q
);

  // Address recipes and classes from the field decoder
  opnd_pkg::mem_ref_t    mem0;
  opnd_pkg::mem_ref_t    mem1;
  opnd_pkg::opnd_class_t cls0;
  opnd_pkg::opnd_class_t cls1;
  logic                  disp_1byte;

  // Effective addresses and the hint data found there
  opnd_pkg::word_t addr0;
  opnd_pkg::word_t addr1;
  opnd_pkg::word_t mem_val0;
  opnd_pkg::word_t mem_val1;

  opnd_field_decode u_decode (
    .instr      (instr),
    .ctl        (ctl),
    .mem0       (mem0),
    .mem1       (mem1),
    .cls0       (cls0),
    .cls1       (cls1),
    .disp_1byte (disp_1byte)
  );

  // One AGU and one hint lookup per memory operand
  opnd_addr_gen u_agu0 (.gprs(gprs), .mem(mem0), .addr(addr0));
  opnd_addr_gen u_agu1 (.gprs(gprs), .mem(mem1), .addr(addr1));

  opnd_hint_match u_hint0 (.addr(addr0), .hint1(hint1), .hint2(hint2), .mem_val(mem_val0));
  opnd_hint_match u_hint1 (.addr(addr1), .hint1(hint1), .hint2(hint2), .mem_val(mem_val1));

  opnd_result_select u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .gprs         (gprs),
    .cls0         (cls0),
    .cls1         (cls1),
    .ctl          (ctl),
    .mem_val0     (mem_val0),
    .mem_val1     (mem_val1),
    .disp_1byte   (disp_1byte),
    .opnd_valid   (opnd_valid),
    .opnd0_val    (opnd0_val),
    .opnd1_val    (opnd1_val),
    .opnd2_val    (opnd2_val),
    .dest0_kind   (dest0_kind),
    .dest1_kind   (dest1_kind),
    .dest0_sel    (dest0_sel),
    .dest1_sel    (dest1_sel),
    .disp_1byte_q (disp_1byte_q)
  );

endmodule

// File: logic/opnd_field_decode.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

module opnd_field_decode (
  input  opnd_pkg::instr_t      instr,
  input  opnd_pkg::opnd_ctl_t   ctl,
  output opnd_pkg::mem_ref_t    mem0,
  output opnd_pkg::mem_ref_t    mem1,
  output opnd_pkg::opnd_class_t cls0,
  output opnd_pkg::opnd_class_t cls1,
  output logic                  disp_1byte
);

  // Raw bytes following the opcode
  logic [7:0]        modrm;
  logic [7:0]        sib;
  logic [1:0]        modrm_mod;
  opnd_pkg::regsel_t modrm_reg;
  opnd_pkg::regsel_t modrm_rm;

  logic has_modrm;
  logic rm_direct;
  logic has_sib;
  logic sib_no_base;
  logic abs_disp32;
  logic disp8;
  logic disp32;

  logic [7:0]      disp_lo8;
  opnd_pkg::word_t disp_lo32;
  opnd_pkg::word_t disp_val;

  // Operand form flags
  logic form_reg;
  logic form_reg_imm;
  logic form_eax_imm;
  logic form_eax_reg;
  logic op0_from_rm;
  logic op1_from_rm;

  // String commands with an implicit memory operand
  logic str0_mem;
  logic str1_mem;
  opnd_pkg::regsel_t str0_base;
  opnd_pkg::regsel_t str1_base;

  opnd_pkg::mem_ref_t modrm_ref;

  // Implicit ESI/EDI recipe, never displaced or indexed
  function automatic opnd_pkg::mem_ref_t implicit_ref(opnd_pkg::regsel_t base);
    return '{base_sel: base, index_sel: '0, scale: '0,
             use_base: 1'b1, use_index: 1'b0, disp: '0};
  endfunction

  assign form_reg     = ctl.opnd_form == `OPND_ENC_REG;
  assign form_reg_imm = ctl.opnd_form == `OPND_ENC_REG_IMM;
  assign form_eax_imm = ctl.opnd_form == `OPND_ENC_EAX_IMM;
  assign form_eax_reg = ctl.opnd_form == `OPND_ENC_EAX_REG;
  assign op0_from_rm  = ctl.opnd_form == `OPND_ENC_MODREGRM_RM;
  assign op1_from_rm  = ctl.opnd_form == `OPND_ENC_MODREGRM_REG;
  assign has_modrm    = op0_from_rm || op1_from_rm;

  assign modrm     = instr[15:8];
  assign sib       = instr[23:16];
  assign modrm_mod = modrm[7:6];
  assign modrm_reg = modrm[5:3];
  assign modrm_rm  = modrm[2:0];

  // mod 11 selects a register, anything else is a memory reference
  assign rm_direct = has_modrm && modrm_mod == `MOD_REG_DIRECT;
  assign has_sib   = has_modrm && !rm_direct && modrm_rm == `RM_SIB;

  // Absolute disp32 forms, with no base register
  assign sib_no_base = has_sib && modrm_mod == `MOD_NO_DISP && sib[2:0] == `RM_NO_BASE;
  assign abs_disp32  = has_modrm && !has_sib && modrm_mod == `MOD_NO_DISP &&
                       modrm_rm == `RM_NO_BASE;

  assign disp8  = has_modrm && modrm_mod == `MOD_DISP8;
  assign disp32 = (has_modrm && modrm_mod == `MOD_DISP32) || abs_disp32 || sib_no_base;

  // Displacement starts after SIB when there is one
  assign disp_lo8  = has_sib ? instr[31:24] : instr[23:16];
  assign disp_lo32 = has_sib ? instr[55:24] : instr[47:16];
  assign disp_val  = disp8  ? {{24{disp_lo8[7]}}, disp_lo8} :
                     disp32 ? disp_lo32 : '0;
  assign disp_1byte = disp8;

  // Operand 0 is the destination side of the string commands
  assign str0_mem  = ctl.opc == `CMD_MOVS || ctl.opc == `CMD_CMPS ||
                     ctl.opc == `CMD_SCAS || ctl.opc == `CMD_STOS;
  assign str1_mem  = ctl.opc == `CMD_MOVS || ctl.opc == `CMD_CMPS ||
                     ctl.opc == `CMD_LODS;
  // CMPS compares [ESI] against [EDI], the others write [EDI] from [ESI]
  assign str0_base = ctl.opc == `CMD_CMPS ? `REG_ESI : `REG_EDI;
  assign str1_base = ctl.opc == `CMD_CMPS ? `REG_EDI : `REG_ESI;

  always_comb begin
    modrm_ref.base_sel  = has_sib ? sib[2:0] : modrm_rm;
    modrm_ref.use_base  = has_sib ? !sib_no_base : !abs_disp32;
    modrm_ref.index_sel = sib[5:3];
    // Index 100 in SIB means no index
    modrm_ref.use_index = has_sib && sib[5:3] != `SIB_NO_INDEX;
    modrm_ref.scale     = has_sib ? sib[7:6] : 2'b00;
    modrm_ref.disp      = disp_val;
  end

  assign mem0 = str0_mem ? implicit_ref(str0_base) : modrm_ref;
  assign mem1 = str1_mem ? implicit_ref(str1_base) : modrm_ref;

  // Operand 0 register sources: opcode bits, r/m, reg, implicit EAX
  always_comb begin
    cls0.is_mem = str0_mem || (op0_from_rm && !rm_direct);
    cls0.is_reg = !str0_mem && (form_reg || form_reg_imm || form_eax_imm ||
                  form_eax_reg || (op0_from_rm && rm_direct) || op1_from_rm);
    if (form_reg || form_reg_imm)
      cls0.reg_sel = instr[2:0];
    else if (op0_from_rm)
      cls0.reg_sel = modrm_rm;
    else if (op1_from_rm)
      cls0.reg_sel = modrm_reg;
    else
      cls0.reg_sel = `REG_EAX;
  end

  // Operand 1 register sources: r/m, reg, opcode bits
  always_comb begin
    cls1.is_mem = str1_mem || (op1_from_rm && !rm_direct);
    cls1.is_reg = !str1_mem && (form_eax_reg || (op1_from_rm && rm_direct) ||
                  op0_from_rm);
    if (op1_from_rm)
      cls1.reg_sel = modrm_rm;
    else if (op0_from_rm)
      cls1.reg_sel = modrm_reg;
    else if (form_eax_reg)
      cls1.reg_sel = instr[2:0];
    else
      cls1.reg_sel = '0;
  end

  // A string override or r/m mode must never leave an operand in both classes
  always_comb begin
    a_cls_excl: assert final (!(cls0.is_reg && cls0.is_mem) && !(cls1.is_reg && cls1.is_mem));
  end

endmodule

// File: logic/opnd_hint_match.sv
`timescale 1ns/1ps

module opnd_hint_match (
  input  opnd_pkg::word_t     addr,
  input  opnd_pkg::mem_hint_t hint1,
  input  opnd_pkg::mem_hint_t hint2,
  output opnd_pkg::word_t     mem_val
);

  logic hit1;
  logic hit2;

  // Only reads carry a usable value
  assign hit1 = !hint1.is_write && hint1.address == addr;
  assign hit2 = !hint2.is_write && hint2.address == addr;

  // Hint 1 wins when both match
  assign mem_val = hit1 ? hint1.data :
                   hit2 ? hint2.data : '0;

endmodule

// File: logic/opnd_macros.svh
`ifndef OPND_MACROS_SVH
`define OPND_MACROS_SVH

// Operand form codes, as sent by the decoder in opnd_ctl_t.opnd_form
// No explicit operands
`define OPND_ENC_NONE          4'd0
// Register in the low three opcode bits
`define OPND_ENC_REG           4'd1
// Register in the low three opcode bits, then an immediate
`define OPND_ENC_REG_IMM       4'd2
// Operand 0 from r/m, operand 1 from reg
`define OPND_ENC_MODREGRM_RM   4'd3
// Operand 0 from reg, operand 1 from r/m
`define OPND_ENC_MODREGRM_REG  4'd4
// Implicit EAX, then an immediate
`define OPND_ENC_EAX_IMM       4'd5
// Implicit EAX, then a register in the low opcode bits
`define OPND_ENC_EAX_REG       4'd6

// Opcode classes the operand stage cares about
`define CMD_OTHER              6'd0
`define CMD_MOVS               6'd20
`define CMD_CMPS               6'd21
`define CMD_SCAS               6'd22
`define CMD_STOS               6'd23
`define CMD_LODS               6'd24

// Register numbers in x86 encoding order
`define REG_EAX                3'd0
`define REG_ECX                3'd1
`define REG_EDX                3'd2
`define REG_EBX                3'd3
`define REG_ESP                3'd4
`define REG_EBP                3'd5
`define REG_ESI                3'd6
`define REG_EDI                3'd7

// Destination kinds reported per operand
`define DEST_NONE              2'd0
`define DEST_REG               2'd1
`define DEST_MEM               2'd2

// ModR/M and SIB special field values
`define MOD_REG_DIRECT         2'b11
`define MOD_DISP8              2'b01
`define MOD_DISP32             2'b10
`define MOD_NO_DISP            2'b00
`define RM_SIB                 3'b100
`define RM_NO_BASE             3'b101
`define SIB_NO_INDEX           3'b100

`endif

// File: logic/opnd_pkg.sv
`include "opnd_macros.svh"

package opnd_pkg;

  // Unescaped instruction, byte 0 (opcode) in the low bits
  typedef logic [71:0] instr_t;
  typedef logic [31:0] word_t;
  typedef logic [2:0]  regsel_t;
  typedef logic [3:0]  opnd_form_t;
  typedef logic [5:0]  opc_t;
  typedef logic [1:0]  dest_kind_t;

  // Register file snapshot
  typedef struct packed {
    word_t eax;
    word_t ecx;
    word_t edx;
    word_t ebx;
    word_t esp;
    word_t ebp;
    word_t esi;
    word_t edi;
  } gpr_set_t;

  // One memory hint from the load/store side
  typedef struct packed {
    logic  is_write;
    word_t address;
    word_t data;
  } mem_hint_t;

  // Decoder side-band for one instruction
  typedef struct packed {
    opc_t       opc;
    opnd_form_t opnd_form;
    logic       opnd0_is_read;
    logic       opnd0_is_write;
    logic       opnd1_is_read;
    logic       opnd1_is_write;
  } opnd_ctl_t;

  // Address recipe of one memory operand
  typedef struct packed {
    regsel_t    base_sel;
    regsel_t    index_sel;
    logic [1:0] scale;
    logic       use_base;
    logic       use_index;
    word_t      disp;
  } mem_ref_t;

  // Operand class, register and memory are exclusive
  typedef struct packed {
    logic    is_reg;
    logic    is_mem;
    regsel_t reg_sel;
  } opnd_class_t;

  // Read one register out of the snapshot
  function automatic word_t gpr_read(gpr_set_t gprs, regsel_t sel);
    case (sel)
      `REG_EAX: return gprs.eax;
      `REG_ECX: return gprs.ecx;
      `REG_EDX: return gprs.edx;
      `REG_EBX: return gprs.ebx;
      `REG_ESP: return gprs.esp;
      `REG_EBP: return gprs.ebp;
      `REG_ESI: return gprs.esi;
      default:  return gprs.edi;
    endcase
  endfunction

endpackage

// File: logic/opnd_result_select.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

module opnd_result_select (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  opnd_pkg::gpr_set_t    gprs,
  input  opnd_pkg::opnd_class_t cls0,
  input  opnd_pkg::opnd_class_t cls1,
  input  opnd_pkg::opnd_ctl_t   ctl,
  input  opnd_pkg::word_t       mem_val0,
  input  opnd_pkg::word_t       mem_val1,
  input  logic                  disp_1byte,
  output logic                  opnd_valid,
  output opnd_pkg::word_t       opnd0_val,
  output opnd_pkg::word_t       opnd1_val,
  output opnd_pkg::word_t       opnd2_val,
  output opnd_pkg::dest_kind_t  dest0_kind,
  output opnd_pkg::dest_kind_t  dest1_kind,
  output opnd_pkg::regsel_t     dest0_sel,
  output opnd_pkg::regsel_t     dest1_sel,
  output logic                  disp_1byte_q
);

  opnd_pkg::word_t      val0;
  opnd_pkg::word_t      val1;
  opnd_pkg::dest_kind_t kind0;
  opnd_pkg::dest_kind_t kind1;
  opnd_pkg::regsel_t    sel0;
  opnd_pkg::regsel_t    sel1;

  // Register value, hint value, or zero
  assign val0 = cls0.is_reg ? opnd_pkg::gpr_read(gprs, cls0.reg_sel) :
                cls0.is_mem ? mem_val0 : '0;
  assign val1 = cls1.is_reg ? opnd_pkg::gpr_read(gprs, cls1.reg_sel) :
                cls1.is_mem ? mem_val1 : '0;

  // Only written operands get a destination
  assign kind0 = !ctl.opnd0_is_write ? `DEST_NONE :
                 cls0.is_reg ? `DEST_REG :
                 cls0.is_mem ? `DEST_MEM : `DEST_NONE;
  assign kind1 = !ctl.opnd1_is_write ? `DEST_NONE :
                 cls1.is_reg ? `DEST_REG :
                 cls1.is_mem ? `DEST_MEM : `DEST_NONE;

  assign sel0 = kind0 == `DEST_REG ? cls0.reg_sel : '0;
  assign sel1 = kind1 == `DEST_REG ? cls1.reg_sel : '0;

  // Operand 2 is not produced by this stage
  assign opnd2_val = '0;

  // One-cycle output stage; data holds while no instruction enters
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      opnd_valid   <= 1'b0;
      opnd0_val    <= '0;
      opnd1_val    <= '0;
      dest0_kind   <= `DEST_NONE;
      dest1_kind   <= `DEST_NONE;
      dest0_sel    <= '0;
      dest1_sel    <= '0;
      disp_1byte_q <= 1'b0;
    end else begin
      opnd_valid <= instr_valid;
      if (instr_valid) begin
        opnd0_val    <= val0;
        opnd1_val    <= val1;
        dest0_kind   <= kind0;
        dest1_kind   <= kind1;
        dest0_sel    <= sel0;
        dest1_sel    <= sel1;
        disp_1byte_q <= disp_1byte;
      end
    end
  end

  // Nothing leaves the stage right after reset
  a_reset_quiet: assert property (@(posedge clk)
    !rst_n |=> !opnd_valid && dest0_kind == `DEST_NONE && dest1_kind == `DEST_NONE);

  // A read-only operand never shows up as a register destination
  a_dest0_write: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid && !ctl.opnd0_is_write |=> dest0_kind != `DEST_REG);
  a_dest1_write: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid && !ctl.opnd1_is_write |=> dest1_kind != `DEST_REG);

endmodule

// File: sim/tb_opnd_fetch.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

module tb_opnd_fetch;

  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 8;
  // Expected operand source is a register for 0..7, else hint 1, hint 2 or zero
  localparam logic [3:0] SRC_H1   = 4'd8;
  localparam logic [3:0] SRC_H2   = 4'd9;
  localparam logic [3:0] SRC_ZERO = 4'd15;
  // Base or index code for no register
  localparam logic [3:0] NOREG    = 4'd8;

  // Hint placement relative to the register values of the current pass
  typedef struct packed {
    logic            wr;
    logic [3:0]      base;
    logic [3:0]      idx;
    logic [1:0]      sc;
    opnd_pkg::word_t off;
    opnd_pkg::word_t data;
  } hint_spec_t;

  // One table row with stimulus and expected outputs
  typedef struct packed {
    opnd_pkg::instr_t     instr;
    opnd_pkg::opnd_ctl_t  ctl;
    hint_spec_t           h1;
    hint_spec_t           h2;
    logic [3:0]           src0;
    logic [3:0]           src1;
    opnd_pkg::dest_kind_t kind0;
    opnd_pkg::dest_kind_t kind1;
    opnd_pkg::regsel_t    sel0;
    opnd_pkg::regsel_t    sel1;
    logic                 disp1;
  } vec_t;

  logic                 clk;
  logic                 rst_n;
  logic                 instr_valid;
  opnd_pkg::instr_t     instr;
  opnd_pkg::opnd_ctl_t  ctl;
  opnd_pkg::gpr_set_t   gprs;
  opnd_pkg::mem_hint_t  hint1;
  opnd_pkg::mem_hint_t  hint2;
  logic                 opnd_valid;
  opnd_pkg::word_t      opnd0_val;
  opnd_pkg::word_t      opnd1_val;
  opnd_pkg::word_t      opnd2_val;
  opnd_pkg::dest_kind_t dest0_kind;
  opnd_pkg::dest_kind_t dest1_kind;
  opnd_pkg::regsel_t    dest0_sel;
  opnd_pkg::regsel_t    dest1_sel;
  logic                 disp_1byte_q;

  vec_t            tbl[$];
  string           names[$];
  opnd_pkg::word_t regs[8];
  int              test_errs;
  int              n_pass;
  int              n_fail;

  opnd_fetch_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Limit scales with the table length
  initial begin
    #1;
    #((tbl.size() * 4 + RST_CYCLES) * PERIOD);
    $display("Watchdog timeout, the DUT did not get through all table entries");
    $display("Something failed");
    $finish;
  end

  function automatic hint_spec_t read_hint(logic [3:0] base, logic [3:0] idx, logic [1:0] sc,
                                           opnd_pkg::word_t off, opnd_pkg::word_t data);
    return {1'b0, base, idx, sc, off, data};
  endfunction

  function automatic hint_spec_t write_hint(logic [3:0] base, opnd_pkg::word_t data);
    return {1'b1, base, NOREG, 2'd0, 32'd0, data};
  endfunction

  // A write hint never supplies data
  function automatic hint_spec_t no_hint();
    return {1'b1, NOREG, NOREG, 2'd0, 64'd0};
  endfunction

  // Base plus scaled index plus offset wraps at 32 bits
  function automatic opnd_pkg::word_t hint_addr(hint_spec_t h);
    opnd_pkg::word_t a;
    a = h.off;
    if (!h.base[3])
      a = a + regs[h.base[2:0]];
    if (!h.idx[3])
      a = a + (regs[h.idx[2:0]] << h.sc);
    return a;
  endfunction

  function automatic opnd_pkg::word_t src_val(logic [3:0] src, vec_t v);
    if (src < 4'd8)
      return regs[src[2:0]];
    else if (src == SRC_H1)
      return v.h1.data;
    else if (src == SRC_H2)
      return v.h2.data;
    return '0;
  endfunction

  task automatic add_vec(input string name, input opnd_pkg::instr_t ins,
                         input opnd_pkg::opnd_ctl_t c, input hint_spec_t h1,
                         input hint_spec_t h2, input logic [3:0] s0, input logic [3:0] s1,
                         input logic [1:0] k0, input logic [1:0] k1,
                         input logic [2:0] d0, input logic [2:0] d1, input logic dsp1);
    names.push_back(name);
    tbl.push_back({ins, c, h1, h2, s0, s1, k0, k1, d0, d1, dsp1});
  endtask

  task automatic build_table();
    // Register forms
    add_vec("inc_reg", 72'h41, {`CMD_OTHER, `OPND_ENC_REG, 4'b1100}, no_hint(), no_hint(),
            `REG_ECX, SRC_ZERO, `DEST_REG, `DEST_NONE, `REG_ECX, 0, 0);
    add_vec("xchg_eax", 72'h92, {`CMD_OTHER, `OPND_ENC_EAX_REG, 4'b1111}, no_hint(), no_hint(),
            `REG_EAX, `REG_EDX, `DEST_REG, `DEST_REG, `REG_EAX, `REG_EDX, 0);
    add_vec("rr_rm", 72'hCB01, {`CMD_OTHER, `OPND_ENC_MODREGRM_RM, 4'b1110}, no_hint(),
            no_hint(), `REG_EBX, `REG_ECX, `DEST_REG, `DEST_NONE, `REG_EBX, 0, 0);
    add_vec("rr_reg", 72'hF78B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110}, no_hint(),
            no_hint(), `REG_ESI, `REG_EDI, `DEST_REG, `DEST_NONE, `REG_ESI, 0, 0);
    // ModR/M memory forms
    add_vec("ind_hit", 72'h038B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            read_hint(`REG_EBX, NOREG, 0, 0, 32'hA000_0005), no_hint(),
            `REG_EAX, SRC_H1, `DEST_REG, `DEST_NONE, `REG_EAX, 0, 0);
    // EBP minus 8 only matches if the disp8 is sign extended
    add_vec("disp8_neg", 72'hF85501, {`CMD_OTHER, `OPND_ENC_MODREGRM_RM, 4'b1110}, no_hint(),
            read_hint(`REG_EBP, NOREG, 0, 32'hFFFF_FFF8, 32'hA000_0006),
            SRC_H2, `REG_EDX, `DEST_MEM, `DEST_NONE, 0, 0, 1);
    add_vec("disp32_both", 72'h000001248E8B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            read_hint(`REG_ESI, NOREG, 0, 32'h124, 32'hA000_0007),
            read_hint(`REG_ESI, NOREG, 0, 32'h124, 32'hB000_0007),
            `REG_ECX, SRC_H1, `DEST_REG, `DEST_NONE, `REG_ECX, 0, 0);
    add_vec("ind_miss", 72'h118B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            read_hint(`REG_ECX, NOREG, 0, 4, 32'hA000_0008),
            read_hint(`REG_ECX, NOREG, 0, 8, 32'hB000_0008),
            `REG_EDX, SRC_ZERO, `DEST_REG, `DEST_NONE, `REG_EDX, 0, 0);
    add_vec("write_only", 72'h118B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            write_hint(`REG_ECX, 32'hA000_0009), no_hint(),
            `REG_EDX, SRC_ZERO, `DEST_REG, `DEST_NONE, `REG_EDX, 0, 0);
    add_vec("abs_disp32", 72'h000123400589, {`CMD_OTHER, `OPND_ENC_MODREGRM_RM, 4'b0110},
            read_hint(NOREG, NOREG, 0, 32'h12340, 32'hA000_000A), no_hint(),
            SRC_H1, `REG_EAX, `DEST_MEM, `DEST_NONE, 0, 0, 0);
    // SIB forms with one scale each
    add_vec("sib_x1", 72'h0A048B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            read_hint(`REG_EDX, `REG_ECX, 0, 0, 32'hA000_000B), no_hint(),
            `REG_EAX, SRC_H1, `DEST_REG, `DEST_NONE, `REG_EAX, 0, 0);
    add_vec("sib_x2_d8", 72'h1058448B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            read_hint(`REG_EAX, `REG_EBX, 1, 32'h10, 32'hA000_000C), no_hint(),
            `REG_EAX, SRC_H1, `DEST_REG, `DEST_NONE, `REG_EAX, 0, 1);
    add_vec("sib_x4_d32", 72'h80000000B1848B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            read_hint(`REG_ECX, `REG_ESI, 2, 32'h8000_0000, 32'hA000_000D), no_hint(),
            `REG_EAX, SRC_H1, `DEST_REG, `DEST_NONE, `REG_EAX, 0, 0);
    add_vec("sib_x8_nobase", 72'h00000400FD048B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            read_hint(NOREG, `REG_EDI, 3, 32'h400, 32'hA000_000E), no_hint(),
            `REG_EAX, SRC_H1, `DEST_REG, `DEST_NONE, `REG_EAX, 0, 0);
    // Index 100 drops the index even with a nonzero scale
    add_vec("sib_noidx", 72'hA4048B, {`CMD_OTHER, `OPND_ENC_MODREGRM_REG, 4'b0110},
            read_hint(`REG_ESP, NOREG, 0, 0, 32'hA000_000F), no_hint(),
            `REG_EAX, SRC_H1, `DEST_REG, `DEST_NONE, `REG_EAX, 0, 0);
    // String commands with implicit ESI/EDI
    add_vec("movs", 72'hA5, {`CMD_MOVS, `OPND_ENC_NONE, 4'b0110},
            read_hint(`REG_EDI, NOREG, 0, 0, 32'hA000_0010),
            read_hint(`REG_ESI, NOREG, 0, 0, 32'hB000_0010),
            SRC_H1, SRC_H2, `DEST_MEM, `DEST_NONE, 0, 0, 0);
    add_vec("cmps", 72'hA7, {`CMD_CMPS, `OPND_ENC_NONE, 4'b1010},
            read_hint(`REG_EDI, NOREG, 0, 0, 32'hA000_0011),
            read_hint(`REG_ESI, NOREG, 0, 0, 32'hB000_0011),
            SRC_H2, SRC_H1, `DEST_NONE, `DEST_NONE, 0, 0, 0);
    add_vec("scas", 72'hAF, {`CMD_SCAS, `OPND_ENC_NONE, 4'b1000},
            read_hint(`REG_EDI, NOREG, 0, 0, 32'hA000_0012), no_hint(),
            SRC_H1, SRC_ZERO, `DEST_NONE, `DEST_NONE, 0, 0, 0);
    add_vec("stos", 72'hAB, {`CMD_STOS, `OPND_ENC_NONE, 4'b0100},
            read_hint(`REG_EDI, NOREG, 0, 0, 32'hA000_0013), no_hint(),
            SRC_H1, SRC_ZERO, `DEST_MEM, `DEST_NONE, 0, 0, 0);
    add_vec("lods", 72'hAD, {`CMD_LODS, `OPND_ENC_NONE, 4'b0010}, no_hint(),
            read_hint(`REG_ESI, NOREG, 0, 0, 32'hB000_0014),
            SRC_ZERO, SRC_H2, `DEST_NONE, `DEST_NONE, 0, 0, 0);
  endtask

  task automatic check_field(input string tname, input string field,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[FAIL] %s %s expected %h actual %h", tname, field, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_test(input string tname);
    if (test_errs == 0) begin
      $display("[PASS] %s", tname);
      n_pass++;
    end else begin
      $display("%s finished with %0d failed checks", tname, test_errs);
      n_fail++;
    end
    test_errs = 0;
  endtask

  task automatic drive_entry(input vec_t v);
    instr_valid = 1'b1;
    instr       = v.instr;
    ctl         = v.ctl;
    hint1       = {v.h1.wr, hint_addr(v.h1), v.h1.data};
    hint2       = {v.h2.wr, hint_addr(v.h2), v.h2.data};
  endtask

  task automatic check_result(input int i, input string tag);
    vec_t  v;
    string tname;
    v     = tbl[i];
    tname = {tag, "/", names[i]};
    assert (opnd_valid === 1'b1) else begin
      $display("%s: opnd_valid did not rise one cycle after the instruction", tname);
      test_errs++;
    end
    check_field(tname, "opnd0_val", src_val(v.src0, v), opnd0_val);
    check_field(tname, "opnd1_val", src_val(v.src1, v), opnd1_val);
    check_field(tname, "opnd2_val", 32'd0, opnd2_val);
    check_field(tname, "dest0_kind", v.kind0, dest0_kind);
    check_field(tname, "dest1_kind", v.kind1, dest1_kind);
    check_field(tname, "dest0_sel", v.sel0, dest0_sel);
    check_field(tname, "dest1_sel", v.sel1, dest1_sel);
    check_field(tname, "disp_1byte_q", v.disp1, disp_1byte_q);
    report_test(tname);
  endtask

  // Entries go in back to back and each is checked while the next one is presented
  task automatic run_pass(input string tag);
    int i;
    gprs = {regs[0], regs[1], regs[2], regs[3], regs[4], regs[5], regs[6], regs[7]};
    for (i = 0; i <= tbl.size(); i++) begin
      @(negedge clk);
      if (i > 0)
        check_result(i - 1, tag);
      if (i < tbl.size())
        drive_entry(tbl[i]);
      else
        instr_valid = 1'b0;
    end
    // No instruction in means no pulse out
    @(negedge clk);
    assert (opnd_valid === 1'b0) else begin
      $display("%s: opnd_valid stayed high with no instruction entering", tag);
      test_errs++;
    end
    report_test({tag, "/idle"});
  endtask

  initial begin
    void'($urandom(32'h9ecb));
    build_table();
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    ctl         = '0;
    gprs        = '0;
    hint1       = '0;
    hint2       = '0;
    test_errs   = 0;
    n_pass      = 0;
    n_fail      = 0;
    // Reset spans eight rising edges and ends on the next falling edge
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_field("reset_quiet", "opnd_valid", 32'd0, opnd_valid);
    check_field("reset_quiet", "dest0_kind", `DEST_NONE, dest0_kind);
    check_field("reset_quiet", "dest1_kind", `DEST_NONE, dest1_kind);
    report_test("reset_quiet");
    // Known register values first and random ones after
    for (int r = 0; r < 8; r++)
      regs[r] = 32'h1000 * (r + 1);
    run_pass("fixed");
    for (int r = 0; r < 8; r++)
      regs[r] = $urandom();
    run_pass("random");
    $display("Tests: %0d, passed: %0d, failed: %0d", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
logic/opnd_pkg.sv
logic/opnd_field_decode.sv
logic/opnd_addr_gen.sv
logic/opnd_hint_match.sv
logic/opnd_result_select.sv
logic/opnd_fetch_top.sv
sim/tb_opnd_fetch.sv
